/* ads1292_pkg.sv */
// ADS1292 read-data frame layout and SPI reader state encoding
// Imported by the reader stage and by the sample interface

package ads1292_pkg;

	// ==========================================================
	// RDATAC frame layout
	// ==========================================================
	// 24-bit status word, then channel 1, then channel 2, MSB first
	localparam int FRAME_BITS = 72;
	localparam int CH_BITS    = 24;
	localparam int HDR_BITS   = 4;    // Top nibble of the status word

	// Status word always begins with 1100 on a healthy frame
	localparam logic [HDR_BITS-1:0] STATUS_HDR = 4'b1100;

	// ==========================================================
	// Reader FSM
	// ==========================================================
	typedef enum logic [1:0] {
		IDLE,     // Waiting for DRDY falling edge
		SELECT,   // CSN low, lead-in before first SCLK
		SHIFT,    // Clocking frame bits in
		HOLD      // Sample parked, offered downstream
	} reader_state_t;

endpackage

/* uart_pkg.sv */
// Host packet layout and state encoding for the UART side
// Imported by the framer and the serializer stages

package uart_pkg;

	// ==========================================================
	// Packet layout
	// ==========================================================
	// Byte 0 is the sequence number, bytes 1..6 carry ch1 then ch2
	localparam int PKT_BYTES = 7;
	localparam int PKT_BITS  = PKT_BYTES * 8;  // 56, same as the old UART word

	typedef logic [7:0] seq_t;   // Wraps at 255

	// ==========================================================
	// Serializer FSM
	// ==========================================================
	typedef enum logic [1:0] {
		IDLE,    // Line high, ready for a packet
		START,   // Start bit, line low
		DATA,    // Eight data bits, LSB first
		STOP     // Stop bit, line high
	} tx_state_t;

endpackage

/* sample_if.sv */
// One two-channel sample passed from the SPI reader to the framer
// Valid/ready handshake, transfer on a clock edge with both high

`timescale 1ns/1ps

interface sample_if import ads1292_pkg::*; ();

	logic [CH_BITS-1:0] ch1;   // Channel 1 raw code
	logic [CH_BITS-1:0] ch2;   // Channel 2 raw code
	logic               valid; // Sample offered, held until taken
	logic               ready; // Sink can take it

	// Reader side
	modport source (
		output ch1, ch2, valid,
		input  ready
	);

	// Framer side
	modport sink (
		input  ch1, ch2, valid,
		output ready
	);

endinterface

/* ads1292_spi_reader.sv */
// Reads one ADS1292 RDATAC frame per DRDY falling edge over SPI mode 1
// Checks the status header and parks good samples for the framer

`timescale 1ns/1ps

module ads1292_spi_reader import ads1292_pkg::*; #(
	parameter int CLK_DIV = 2                 // Clocks per SCLK half period
) (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_drdy_n,                // Data ready, active low
	input  logic     i_miso,
	output logic     o_sclk,
	output logic     o_csn,
	output logic     o_sync_err,              // Sticky, bad header seen
	output logic     o_overrun,               // Sticky, DRDY while busy
	sample_if.source sample
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int CNT_W = $clog2(FRAME_BITS + 1);

	reader_state_t         state;
	logic [2:0]            drdy_sync;         // [1:0] sync chain, [2] edge history
	logic                  drdy_fall;
	logic [DIV_W-1:0]      div_cnt;
	logic                  div_tick;
	logic [CNT_W-1:0]      bit_cnt;           // Falling SCLK edges so far
	logic                  frame_done;
	logic                  sclk_fall;
	logic [FRAME_BITS-1:0] shift_q;
	logic                  hdr_ok;
	logic [CH_BITS-1:0]    ch1_q, ch2_q;      // Hold register

	// ==========================================================
	// DRDY synchronizer and edge detect
	// ==========================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			drdy_sync <= '1;                  // Line idles high
		else
			drdy_sync <= {drdy_sync[1:0], i_drdy_n};
	end
	assign drdy_fall = drdy_sync[2] & ~drdy_sync[1];

	assign div_tick   = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign frame_done = (bit_cnt == CNT_W'(FRAME_BITS));
	assign sclk_fall  = (state == SHIFT) && o_sclk && div_tick && !frame_done;
	assign hdr_ok     = (shift_q[FRAME_BITS-1 -: HDR_BITS] == STATUS_HDR);

	// ==========================================================
	// Control FSM
	// ==========================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= IDLE;
			o_csn      <= 1'b1;
			o_sclk     <= 1'b0;
			div_cnt    <= '0;
			bit_cnt    <= '0;
			o_sync_err <= 1'b0;
			o_overrun  <= 1'b0;
		end else begin
			if (drdy_fall && state != IDLE)
				o_overrun <= 1'b1;            // Frame lost, chip moved on
			case (state)
				IDLE: if (drdy_fall) begin
					o_csn   <= 1'b0;
					div_cnt <= '0;
					bit_cnt <= '0;
					state   <= SELECT;
				end
				SELECT: if (div_tick) begin   // CSN setup time done
					div_cnt <= '0;
					o_sclk  <= 1'b1;
					state   <= SHIFT;
				end else
					div_cnt <= div_cnt + 1'b1;
				SHIFT: if (frame_done) begin
					o_csn <= 1'b1;            // Release chip
					if (hdr_ok)
						state <= HOLD;
					else begin
						o_sync_err <= 1'b1;   // Frame dropped
						state      <= IDLE;
					end
				end else if (div_tick) begin
					div_cnt <= '0;
					o_sclk  <= ~o_sclk;
					if (o_sclk)
						bit_cnt <= bit_cnt + 1'b1;
				end else
					div_cnt <= div_cnt + 1'b1;
				HOLD: if (sample.ready)
					state <= IDLE;            // Framer took it
				default: state <= IDLE;
			endcase
		end
	end

	// Frame shift and hold register, MSB first
	always_ff @(posedge i_clk) begin
		if (sclk_fall)
			shift_q <= {shift_q[FRAME_BITS-2:0], i_miso};
		if (state == SHIFT && frame_done && hdr_ok) begin
			ch1_q <= shift_q[2*CH_BITS-1:CH_BITS];
			ch2_q <= shift_q[CH_BITS-1:0];
		end
	end

	assign sample.ch1   = ch1_q;
	assign sample.ch2   = ch2_q;
	assign sample.valid = (state == HOLD);

endmodule

/* sample_framer.sv */
// Wraps each accepted sample in a 7-byte, sequence-numbered host packet
// Holds one packet until the serializer takes it

`timescale 1ns/1ps

module sample_framer import ads1292_pkg::*; import uart_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	sample_if.sink              sample,
	output logic [PKT_BITS-1:0] o_pkt_data,
	output logic                o_pkt_valid,
	input  logic                i_pkt_ready
);

	seq_t seq_q;       // Next sequence number to stamp
	logic take;        // Sample transfer this cycle

	// Reorder a channel so its MSB byte lands in the lowest byte slot
	function automatic logic [CH_BITS-1:0] msb_first(input logic [CH_BITS-1:0] v);
		return {v[7:0], v[15:8], v[23:16]};
	endfunction

	// Room when empty, or when the held packet leaves this cycle
	assign sample.ready = !o_pkt_valid || i_pkt_ready;
	assign take         = sample.valid && sample.ready;

	// ==========================================================
	// Packet register and sequence counter
	// ==========================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_pkt_valid <= 1'b0;
			seq_q       <= '0;
		end else begin
			if (take) begin
				o_pkt_valid <= 1'b1;
				seq_q       <= seq_q + 1'b1;
			end else if (i_pkt_ready)
				o_pkt_valid <= 1'b0;      // Drained, nothing new
		end
	end

	// Byte 0 seq, bytes 1..3 ch1, bytes 4..6 ch2
	always_ff @(posedge i_clk) begin
		if (take)
			o_pkt_data <= {msb_first(sample.ch2), msb_first(sample.ch1), seq_q};
	end

endmodule

/* uart_tx_serializer.sv */
// Sends one 56-bit packet as seven back-to-back 8N1 UART bytes
// Byte 0 first, each byte LSB first, line idles high

`timescale 1ns/1ps

module uart_tx_serializer import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 8            // Clock cycles per UART bit
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic [PKT_BITS-1:0] i_pkt_data,
	input  logic                i_pkt_valid,
	output logic                o_pkt_ready,
	output logic                o_txd
);

	localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	tx_state_t           state;
	logic [BAUD_W-1:0]   baud_cnt;
	logic                bit_end;             // Last cycle of current bit
	logic [2:0]          bit_idx;             // Data bit within byte
	logic [2:0]          byte_idx;            // Byte within packet
	logic [PKT_BITS-1:0] shift_q;             // Latched packet, shifts right

	assign o_pkt_ready = (state == IDLE);
	assign bit_end     = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

	// ==========================================================
	// Bit timing and line FSM
	// ==========================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= IDLE;
			o_txd    <= 1'b1;
			baud_cnt <= '0;
			bit_idx  <= '0;
			byte_idx <= '0;
		end else begin
			if (state == IDLE || bit_end)
				baud_cnt <= '0;
			else
				baud_cnt <= baud_cnt + 1'b1;
			case (state)
				IDLE: if (i_pkt_valid) begin
					o_txd    <= 1'b0;         // Start bit of byte 0
					byte_idx <= '0;
					state    <= START;
				end
				START: if (bit_end) begin
					o_txd   <= shift_q[0];
					bit_idx <= '0;
					state   <= DATA;
				end
				DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						o_txd <= 1'b1;        // Stop bit
						state <= STOP;
					end else begin
						o_txd   <= shift_q[0];
						bit_idx <= bit_idx + 1'b1;
					end
				end
				STOP: if (bit_end) begin
					if (byte_idx == 3'(PKT_BYTES - 1))
						state <= IDLE;        // Packet done, line stays high
					else begin
						o_txd    <= 1'b0;
						byte_idx <= byte_idx + 1'b1;
						state    <= START;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Packet latch, one bit consumed per data bit sent
	always_ff @(posedge i_clk) begin
		if (state == IDLE && i_pkt_valid)
			shift_q <= i_pkt_data;
		else if (bit_end && (state == START || (state == DATA && bit_idx != 3'd7)))
			shift_q <= shift_q >> 1;
	end

endmodule

/* khu_sensor_top.sv */
// Sensor acquisition top: ADS1292 SPI reader, packet framer, UART TX
// Single clock; timing parameters are set here and passed down

`timescale 1ns/1ps

module khu_sensor_top import uart_pkg::*; #(
	parameter int CLK_DIV      = 2,   // SCLK half period in clocks
	parameter int CLKS_PER_BIT = 8    // UART bit time in clocks
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_drdy_n,            // ADS1292 DRDY, active low
	input  logic i_miso,              // ADS1292 DOUT
	output logic o_sclk,
	output logic o_csn,
	output logic o_txd,               // To host PC
	output logic o_sync_err,
	output logic o_overrun
);

	// ==========================================================
	// Internal links
	// ==========================================================
	sample_if u_sample ();            // Reader to framer

	logic [PKT_BITS-1:0] w_pkt_data;  // Framer to serializer
	logic                w_pkt_valid;
	logic                w_pkt_ready;

	ads1292_spi_reader #(.CLK_DIV(CLK_DIV)) u_reader (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_drdy_n   (i_drdy_n),
		.i_miso     (i_miso),
		.o_sclk     (o_sclk),
		.o_csn      (o_csn),
		.o_sync_err (o_sync_err),
		.o_overrun  (o_overrun),
		.sample     (u_sample.source)
	);

	sample_framer u_framer (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.sample      (u_sample.sink),
		.o_pkt_data  (w_pkt_data),
		.o_pkt_valid (w_pkt_valid),
		.i_pkt_ready (w_pkt_ready)
	);

	uart_tx_serializer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_pkt_data  (w_pkt_data),
		.i_pkt_valid (w_pkt_valid),
		.o_pkt_ready (w_pkt_ready),
		.o_txd       (o_txd)
	);

endmodule

/* tb_khu_sensor_tasks.svh */
// Value check, frame and packet helpers and the directed tests
// Included into the testbench top module and uses its signals

task automatic compare_value(input string test, input logic [63:0] expected,
		input logic [63:0] actual);
	if (expected !== actual) begin
		$display("MISMATCH %s expected=%0h actual=%0h", test, expected, actual);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	end
endtask

// Status word with header nibble then ch1 then ch2
function automatic logic [71:0] make_frame(input logic [3:0] hdr,
		input logic [23:0] ch1, input logic [23:0] ch2);
	return {hdr, 20'h50A0F, ch1, ch2};
endfunction

// Byte 0 is the sequence number and bytes 1 to 6 carry ch1 then ch2 MSB byte first
function automatic logic [55:0] expected_packet(input logic [7:0] seq,
		input logic [71:0] frame);
	logic [55:0] pkt;
	pkt[7:0] = seq;
	for (int k = 0; k < 3; k++) begin
		pkt[8*(1+k) +: 8] = frame[47 - 8*k -: 8];   // Byte 1+k from ch1
		pkt[8*(4+k) +: 8] = frame[23 - 8*k -: 8];   // Byte 4+k from ch2
	end
	return pkt;
endfunction

task automatic random_frame(output logic [71:0] frame);
	logic [23:0] c1, c2;
	c1    = 24'($urandom);
	c2    = 24'($urandom);
	frame = make_frame(4'b1100, c1, c2);
endtask

// DRDY low for two cycles with the frame staged in the model
task automatic fire_drdy(input logic [71:0] frame);
	@(posedge clk);
	spi_next <= frame;
	i_drdy_n <= 1'b0;
	repeat (2) @(posedge clk);
	i_drdy_n <= 1'b1;
endtask

task automatic wait_packet(output logic [55:0] pkt);
	while (rx_q.size() == 0)
		@(posedge clk);
	pkt = rx_q.pop_front();
endtask

// ==========================================================
// Directed tests
// ==========================================================
task automatic check_reset_levels();
	@(posedge clk);
	compare_value("reset o_txd", 64'd1, 64'(o_txd));
	compare_value("reset o_csn", 64'd1, 64'(o_csn));
	compare_value("reset o_sclk", 64'd0, 64'(o_sclk));
	compare_value("reset o_sync_err", 64'd0, 64'(o_sync_err));
	compare_value("reset o_overrun", 64'd0, 64'(o_overrun));
endtask

task automatic send_single_frame();
	logic [71:0] frame;
	logic [55:0] pkt;
	frame = make_frame(4'b1100, 24'h123456, 24'hABCDEF);
	fire_drdy(frame);
	wait_packet(pkt);
	compare_value("single frame", 64'(expected_packet(8'd0, frame)), 64'(pkt));
	exp_seq = 8'd1;
endtask

task automatic stream_frames();
	logic [71:0] frame;
	logic [55:0] pkt;
	for (int i = 0; i < 8; i++) begin
		random_frame(frame);
		fire_drdy(frame);
		wait_packet(pkt);                  // One in flight at a time
		compare_value("stream", 64'(expected_packet(exp_seq, frame)), 64'(pkt));
		exp_seq = exp_seq + 8'd1;
	end
	compare_value("stream o_overrun", 64'd0, 64'(o_overrun));
endtask

task automatic reject_bad_header();
	logic [71:0] frame;
	logic [55:0] pkt;
	fire_drdy(make_frame(4'b1010, 24'h0F0F0F, 24'hF0F0F0));
	repeat (FRAME_CYCLES + PKT_CYCLES) begin
		@(posedge clk);
		compare_value("bad header line idle", 64'd1, 64'(o_txd));
	end
	compare_value("bad header no packet", 64'd0, 64'(rx_q.size()));
	compare_value("bad header o_sync_err", 64'd1, 64'(o_sync_err));
	random_frame(frame);                   // Recovery frame
	fire_drdy(frame);
	wait_packet(pkt);
	compare_value("after bad header", 64'(expected_packet(exp_seq, frame)), 64'(pkt));
	exp_seq = exp_seq + 8'd1;
endtask

task automatic burst_overrun();
	logic [71:0] sent[$];
	logic [71:0] frame;
	logic [55:0] pkt;
	logic        found;
	int          pos;
	int          quiet;
	for (int i = 0; i < 10; i++) begin
		random_frame(frame);
		sent.push_back(frame);
		fire_drdy(frame);
		repeat (97) @(posedge clk);        // Edge every 100 cycles
	end
	quiet = 0;
	while (quiet < FRAME_CYCLES + 20 * CLKS_PER_BIT) begin
		@(posedge clk);
		quiet = (o_txd === 1'b1) ? quiet + 1 : 0;   // Drain until line rests
	end
	compare_value("overrun o_overrun", 64'd1, 64'(o_overrun));
	compare_value("overrun any packet", 64'd1, 64'(rx_q.size() > 0));
	pos = 0;
	while (rx_q.size() > 0) begin
		pkt   = rx_q.pop_front();
		found = 1'b0;
		compare_value("overrun seq", 64'(exp_seq), 64'(pkt[7:0]));
		while (!found && pos < sent.size()) begin
			if (pkt == expected_packet(exp_seq, sent[pos]))
				found = 1'b1;              // Skipped frames were overrun
			pos++;
		end
		compare_value("overrun frame order", 64'd1, 64'(found));
		exp_seq = exp_seq + 8'd1;
	end
endtask

/* tb_khu_sensor.sv */
// Testbench for the sensor acquisition path
// Wraps the DUT in an ADS1292 SPI model and a UART receiver model for directed tests

`timescale 1ns/1ps

module tb_khu_sensor;

	localparam int CLK_DIV      = 2;
	localparam int CLKS_PER_BIT = 8;
	localparam int FRAME_CYCLES = 8 + CLK_DIV * (1 + 2 * 72);  // DRDY edge to CSN high plus margin
	localparam int PKT_CYCLES   = 7 * 10 * CLKS_PER_BIT;       // Seven 8N1 bytes
	localparam int MAX_CYCLES   = 20000;   // About 20 frame and packet times

	logic        clk;
	logic        i_rst_n, i_drdy_n, i_miso;
	logic        o_sclk, o_csn, o_txd, o_sync_err, o_overrun;
	logic [71:0] spi_next;                 // Frame returned on the next read
	logic [55:0] rx_q[$];                  // Packets decoded from o_txd
	logic [7:0]  exp_seq;                  // Next sequence number expected
	int          cycle_cnt;

	`include "tb_khu_sensor_tasks.svh"

	khu_sensor_top #(.CLK_DIV(CLK_DIV), .CLKS_PER_BIT(CLKS_PER_BIT)) UUT (
		.i_clk      (clk),
		.i_rst_n    (i_rst_n),
		.i_drdy_n   (i_drdy_n),
		.i_miso     (i_miso),
		.o_sclk     (o_sclk),
		.o_csn      (o_csn),
		.o_txd      (o_txd),
		.o_sync_err (o_sync_err),
		.o_overrun  (o_overrun)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;             // 8 ns period
	end

	// ==========================================================
	// ADS1292 model driving the next bit after each rising SCLK
	// ==========================================================
	initial begin : spi_model
		logic [71:0] shift;
		logic        sclk_d;
		i_miso = 1'b0;
		shift  = '0;
		sclk_d = 1'b0;
		forever begin
			@(posedge clk);
			if (o_csn !== 1'b0)
				shift <= spi_next;         // Frame frozen once CSN drops
			else if (o_sclk && !sclk_d) begin
				i_miso <= shift[71];       // MSB first
				shift  <= shift << 1;
			end
			sclk_d <= o_sclk;
		end
	end

	// UART receiver sampling mid-bit into seven-byte packets
	initial begin : uart_model
		logic [55:0] pkt;
		logic [7:0]  rx_byte;
		pkt     = '0;
		rx_byte = '0;
		wait (i_rst_n === 1'b1);           // Line is only defined once out of reset
		forever begin
			for (int b = 0; b < 7; b++) begin
				@(posedge clk);
				while (o_txd !== 1'b0)
					@(posedge clk);        // Hunt for start bit
				repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
				for (int k = 0; k < 8; k++) begin
					repeat (CLKS_PER_BIT) @(posedge clk);
					rx_byte = {o_txd, rx_byte[7:1]};   // LSB first
				end
				repeat (CLKS_PER_BIT) @(posedge clk);
				compare_value("uart stop bit", 64'd1, 64'(o_txd));
				pkt = {rx_byte, pkt[55:8]};            // Byte 0 ends lowest
			end
			rx_q.push_back(pkt);
		end
	end

	// Watchdog
	initial begin
		cycle_cnt = 0;
		forever begin
			@(posedge clk);
			cycle_cnt++;
			if (cycle_cnt >= MAX_CYCLES) begin
				$display("timeout: no packet received");
				$display("Result: FAILED");
				$fatal(1, "cycle limit reached");
			end
		end
	end

	// ==========================================================
	// Test sequence
	// ==========================================================
	initial begin
		void'($urandom(31855));
		exp_seq  = 8'd0;
		i_rst_n  = 1'b0;
		i_drdy_n = 1'b1;
		spi_next = '0;
		repeat (4) @(posedge clk);         // Reset held over 4 edges
		i_rst_n <= 1'b1;
		check_reset_levels();
		send_single_frame();
		stream_frames();
		reject_bad_header();
		burst_overrun();
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* khu_sensor.f */
+incdir+.
ads1292_pkg.sv
uart_pkg.sv
sample_if.sv
ads1292_spi_reader.sv
sample_framer.sv
uart_tx_serializer.sv
khu_sensor_top.sv
tb_khu_sensor.sv

/* Makefile */
# Verilator build and run for the sensor acquisition path
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_khu_sensor
FLIST     = khu_sensor.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
